// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // data memory window
    localparam logic [31:0] MEM_BASE  = 32'h8000_0000;
    localparam int          MEM_WORDS = 256;
    localparam int          MEM_AW    = 8;             // word index bits

    // one-hot access size from decode
    localparam logic [2:0] SZ_BYTE = 3'b001;
    localparam logic [2:0] SZ_HALF = 3'b010;
    localparam logic [2:0] SZ_WORD = 3'b100;

    // axsize encodings, bytes = 2**size
    localparam logic [2:0] AXI_SIZE_BYTE = 3'h0;
    localparam logic [2:0] AXI_SIZE_HALF = 3'h1;
    localparam logic [2:0] AXI_SIZE_WORD = 3'h2;

    // xresp encodings
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    localparam int FAULT_CNT_W = 8;                    // saturates at 255

endpackage

// File: hdl/lsu_core.sv
`timescale 1ns/1ps

module lsu_core
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // request from execute
    input  logic        exu_valid,
    output logic        lsu_ready,
    input  logic        is_load,
    input  logic        is_store,
    input  logic [2:0]  size,
    input  logic        load_unsigned,
    input  logic [31:0] addr,
    input  logic [31:0] store_data,

    // result to writeback
    input  logic        wbu_ready,
    output logic        lsu_valid,
    output logic [31:0] raw_rdata,
    output logic [31:0] res_addr,
    output logic [2:0]  res_size,
    output logic        res_unsigned,
    output logic        res_load,
    output logic        access_fault,

    // axi master
    output logic [31:0] araddr,
    output logic [2:0]  arsize,
    output logic        arvalid,
    input  logic        arready,
    input  logic [31:0] rdata,
    input  logic [1:0]  rresp,
    input  logic        rvalid,
    output logic        rready,
    output logic [31:0] awaddr,
    output logic [2:0]  awsize,
    output logic        awvalid,
    input  logic        awready,
    output logic [31:0] wdata,
    output logic [3:0]  wstrb,
    output logic        wvalid,
    input  logic        wready,
    input  logic [1:0]  bresp,
    input  logic        bvalid,
    output logic        bready
);

    logic        busy;
    logic        accept;
    logic        mem_op;
    logic        misaligned;
    logic [1:0]  offset;
    logic [2:0]  req_axsize;
    logic [2:0]  ax_size;
    logic [3:0]  req_strb;
    logic [31:0] req_wdata;

    assign lsu_ready = !busy;
    assign accept    = exu_valid && !busy;
    assign mem_op    = is_load || is_store;
    assign offset    = addr[1:0];

    always_comb begin
        case (size)
            SZ_BYTE: begin
                req_axsize = AXI_SIZE_BYTE;
                req_strb   = 4'b0001 << offset;
            end
            SZ_HALF: begin
                req_axsize = AXI_SIZE_HALF;
                req_strb   = 4'b0011 << offset;
            end
            default: begin                          // word, also for bad codes
                req_axsize = AXI_SIZE_WORD;
                req_strb   = 4'b1111;
            end
        endcase
    end

    assign misaligned = (req_axsize == AXI_SIZE_HALF && offset[0]) ||
                        (req_axsize == AXI_SIZE_WORD && offset != 2'b00);

    assign req_wdata = store_data << {offset, 3'b000};   // lane align

    // one bus address per request, shared by both channels
    assign araddr = res_addr;
    assign awaddr = res_addr;
    assign arsize = ax_size;
    assign awsize = ax_size;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy         <= 1'b0;
            lsu_valid    <= 1'b0;
            access_fault <= 1'b0;
            res_load     <= 1'b0;
            arvalid      <= 1'b0;
            rready       <= 1'b0;
            awvalid      <= 1'b0;
            wvalid       <= 1'b0;
            bready       <= 1'b0;
        end else if (!busy) begin
            if (exu_valid) begin
                busy         <= 1'b1;
                res_load     <= is_load;
                access_fault <= mem_op && misaligned;
                if (!mem_op || misaligned) begin
                    lsu_valid <= 1'b1;              // no bus access
                end else if (is_load) begin
                    arvalid <= 1'b1;
                end else begin
                    awvalid <= 1'b1;
                    wvalid  <= 1'b1;
                end
            end
        end else begin
            if (arvalid && arready) begin
                arvalid <= 1'b0;
                rready  <= 1'b1;
            end
            if (rvalid && rready) begin
                rready       <= 1'b0;
                lsu_valid    <= 1'b1;
                access_fault <= rresp != RESP_OKAY;
            end
            if (awvalid && awready) begin
                awvalid <= 1'b0;
                bready  <= 1'b1;
            end
            if (wvalid && wready) begin
                wvalid <= 1'b0;                     // may land before or after aw
            end
            if (bvalid && bready) begin
                bready       <= 1'b0;
                lsu_valid    <= 1'b1;
                access_fault <= bresp != RESP_OKAY;
            end
            if (lsu_valid && wbu_ready) begin
                lsu_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            res_addr     <= addr;
            res_size     <= size;
            res_unsigned <= load_unsigned;
            raw_rdata    <= 32'h0;
            ax_size      <= req_axsize;
            wdata        <= req_wdata;
            wstrb        <= req_strb;
        end else if (rvalid && rready) begin
            raw_rdata <= rdata;
        end
    end

endmodule

// File: hdl/load_format.sv
`timescale 1ns/1ps

module load_format
    import lsu_pkg::*;
(
    input  logic [31:0] raw_rdata,
    input  logic [31:0] res_addr,
    input  logic [2:0]  res_size,
    input  logic        res_unsigned,
    input  logic        is_load_res,
    output logic [31:0] result
);

    logic [31:0] shifted;
    logic [31:0] loaded;

    assign shifted = raw_rdata >> {res_addr[1:0], 3'b000};   // wanted lane to bit 0

    always_comb begin
        case (res_size)
            SZ_BYTE: begin
                if (res_unsigned) begin
                    loaded = {24'h0, shifted[7:0]};
                end else begin
                    loaded = {{24{shifted[7]}}, shifted[7:0]};
                end
            end
            SZ_HALF: begin
                if (res_unsigned) begin
                    loaded = {16'h0, shifted[15:0]};
                end else begin
                    loaded = {{16{shifted[15]}}, shifted[15:0]};
                end
            end
            default: begin
                loaded = shifted;                   // word, offset is zero
            end
        endcase
    end

    // stores and alu passthrough return the address
    assign result = is_load_res ? loaded : res_addr;

endmodule

// File: hdl/axi_sram.sv
`timescale 1ns/1ps

module axi_sram
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic [31:0] araddr,
    input  logic [2:0]  arsize,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,

    input  logic [31:0] awaddr,
    input  logic [2:0]  awsize,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready
);

    logic [31:0]       mem [MEM_WORDS];
    logic              ar_fire;
    logic              aw_fire;
    logic [1:0]        ar_code;
    logic [1:0]        aw_code;
    logic [MEM_AW-1:0] ar_idx;
    logic [MEM_AW-1:0] aw_idx;

    function automatic logic [1:0] decode(input logic [31:0] a, input logic [2:0] sz);
        logic hit;
        logic bad;
        hit = (a - MEM_BASE) < 32'(MEM_WORDS * 4);
        case (sz)
            AXI_SIZE_BYTE: bad = 1'b0;
            AXI_SIZE_HALF: bad = a[0];
            AXI_SIZE_WORD: bad = a[1:0] != 2'b00;
            default:       bad = 1'b1;          // wider than the bus
        endcase
        if (!hit) begin
            decode = RESP_DECERR;
        end else if (bad) begin
            decode = RESP_SLVERR;
        end else begin
            decode = RESP_OKAY;
        end
    endfunction

    assign arready = !rvalid;
    assign awready = awvalid && wvalid && !bvalid;  // take both channels at once
    assign wready  = awready;

    assign ar_fire = arvalid && arready;
    assign aw_fire = awvalid && awready;
    assign ar_code = decode(araddr, arsize);
    assign aw_code = decode(awaddr, awsize);
    assign ar_idx  = araddr[MEM_AW+1:2];
    assign aw_idx  = awaddr[MEM_AW+1:2];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (ar_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
            if (aw_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rresp <= ar_code;
            rdata <= (ar_code == RESP_OKAY) ? mem[ar_idx] : 32'h0;
        end
        if (aw_fire) begin
            bresp <= aw_code;
            if (aw_code == RESP_OKAY) begin
                for (int i = 0; i < 4; i++) begin
                    if (wstrb[i]) begin
                        mem[aw_idx][8*i +: 8] <= wdata[8*i +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: hdl/fault_log.sv
`timescale 1ns/1ps

module fault_log
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fault_event,
    input  logic [31:0]            event_addr,
    input  logic                   fault_clear,
    output logic                   fault_valid,
    output logic [31:0]            fault_addr,
    output logic [FAULT_CNT_W-1:0] fault_count
);

    logic cnt_full;

    assign cnt_full = &fault_count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fault_valid <= 1'b0;
            fault_addr  <= 32'h0;
            fault_count <= '0;
        end else if (fault_clear) begin
            fault_valid <= 1'b0;                    // clear wins over a same-cycle fault
            fault_addr  <= 32'h0;
            fault_count <= '0;
        end else if (fault_event) begin
            if (!fault_valid) begin
                fault_valid <= 1'b1;
                fault_addr  <= event_addr;          // first one only
            end
            if (!cnt_full) begin
                fault_count <= fault_count + 1'b1;
            end
        end
    end

endmodule

// File: hdl/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys
    import lsu_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   exu_valid,
    output logic                   lsu_ready,
    input  logic                   is_load,
    input  logic                   is_store,
    input  logic [2:0]             size,
    input  logic                   load_unsigned,
    input  logic [31:0]            addr,
    input  logic [31:0]            wdata,
    input  logic                   wbu_ready,
    output logic                   lsu_valid,
    output logic [31:0]            result,
    output logic                   access_fault,
    input  logic                   fault_clear,
    output logic                   fault_valid,
    output logic [31:0]            fault_addr,
    output logic [FAULT_CNT_W-1:0] fault_count
);

    logic [31:0] raw_rdata;
    logic [31:0] res_addr;
    logic [2:0]  res_size;
    logic        res_unsigned;
    logic        res_load;

    logic [31:0] axi_araddr;
    logic [2:0]  axi_arsize;
    logic        axi_arvalid;
    logic        axi_arready;
    logic [31:0] axi_rdata;
    logic [1:0]  axi_rresp;
    logic        axi_rvalid;
    logic        axi_rready;
    logic [31:0] axi_awaddr;
    logic [2:0]  axi_awsize;
    logic        axi_awvalid;
    logic        axi_awready;
    logic [31:0] axi_wdata;
    logic [3:0]  axi_wstrb;
    logic        axi_wvalid;
    logic        axi_wready;
    logic [1:0]  axi_bresp;
    logic        axi_bvalid;
    logic        axi_bready;

    wire handover_fault = lsu_valid & wbu_ready & access_fault;

    lsu_core lsu0 (
        .clk(clk), .rst(rst),
        .exu_valid(exu_valid), .lsu_ready(lsu_ready),
        .is_load(is_load), .is_store(is_store), .size(size),
        .load_unsigned(load_unsigned), .addr(addr), .store_data(wdata),
        .wbu_ready(wbu_ready), .lsu_valid(lsu_valid), .raw_rdata(raw_rdata),
        .res_addr(res_addr), .res_size(res_size), .res_unsigned(res_unsigned),
        .res_load(res_load), .access_fault(access_fault),
        .araddr(axi_araddr), .arsize(axi_arsize), .arvalid(axi_arvalid),
        .arready(axi_arready), .rdata(axi_rdata), .rresp(axi_rresp),
        .rvalid(axi_rvalid), .rready(axi_rready),
        .awaddr(axi_awaddr), .awsize(axi_awsize), .awvalid(axi_awvalid),
        .awready(axi_awready), .wdata(axi_wdata), .wstrb(axi_wstrb),
        .wvalid(axi_wvalid), .wready(axi_wready),
        .bresp(axi_bresp), .bvalid(axi_bvalid), .bready(axi_bready)
    );

    load_format fmt0 (
        .raw_rdata(raw_rdata), .res_addr(res_addr), .res_size(res_size),
        .res_unsigned(res_unsigned), .is_load_res(res_load), .result(result)
    );

    axi_sram mem0 (
        .clk(clk), .rst(rst),
        .araddr(axi_araddr), .arsize(axi_arsize), .arvalid(axi_arvalid),
        .arready(axi_arready), .rdata(axi_rdata), .rresp(axi_rresp),
        .rvalid(axi_rvalid), .rready(axi_rready),
        .awaddr(axi_awaddr), .awsize(axi_awsize), .awvalid(axi_awvalid),
        .awready(axi_awready), .wdata(axi_wdata), .wstrb(axi_wstrb),
        .wvalid(axi_wvalid), .wready(axi_wready),
        .bresp(axi_bresp), .bvalid(axi_bvalid), .bready(axi_bready)
    );

    fault_log flog0 (
        .clk(clk), .rst(rst),
        .fault_event(handover_fault), .event_addr(res_addr),
        .fault_clear(fault_clear), .fault_valid(fault_valid),
        .fault_addr(fault_addr), .fault_count(fault_count)
    );

endmodule

// File: testbench/mem_subsys_assertions.sv
`timescale 1ns/1ps

module mem_subsys_assertions (
    input logic        clk,
    input logic        rst,
    input logic        lsu_ready,
    input logic        lsu_valid,
    input logic        wbu_ready,
    input logic [31:0] raw_rdata,
    input logic [31:0] res_addr,
    input logic [2:0]  res_size,
    input logic        res_unsigned,
    input logic        res_load,
    input logic        access_fault,
    input logic [31:0] araddr,
    input logic [31:0] awaddr,
    input logic [31:0] rdata,
    input logic [31:0] wdata,
    input logic [3:0]  wstrb,
    input logic        arvalid, arready, rvalid, rready,
    input logic        awvalid, awready, wvalid, wready, bvalid, bready
);

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid dropped before arready");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid dropped before awready");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid dropped before wready");
    r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("rvalid dropped before rready");
    b_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");
    one_channel: assert property (@(posedge clk) disable iff (rst) !(arvalid && awvalid))
        else $error("read and write address valid together");
    result_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_valid && !wbu_ready |=> lsu_valid && $stable(raw_rdata) && $stable(res_addr)
            && $stable(res_size) && $stable(res_unsigned) && $stable(res_load)
            && $stable(access_fault))
        else $error("result changed while wbu_ready low");
    busy_ready: assert property (@(posedge clk) disable iff (rst) lsu_valid |-> !lsu_ready)
        else $error("lsu_ready high with a result pending");

endmodule

bind lsu_core mem_subsys_assertions chk0 (.*);

// File: testbench/mem_subsys_tb.sv
`timescale 1ns/1ps

module mem_subsys_tb
    import lsu_pkg::*;
();

    localparam int N_WORDS     = 16;
    localparam int N_SUB       = 12;
    localparam int N_ALU       = 8;
    localparam int TOTAL_OPS   = 2 * N_WORDS + 4 * 13 + 2 * N_SUB + 6 + N_ALU;
    localparam int CYCLE_LIMIT = 50 * TOTAL_OPS;

    logic                   clk, rst, fault_clear;
    logic                   exu_valid, lsu_ready, is_load, is_store, load_unsigned;
    logic                   wbu_ready, lsu_valid, access_fault, fault_valid;
    logic [2:0]             size;
    logic [31:0]            addr, wdata, result, fault_addr;
    logic [FAULT_CNT_W-1:0] fault_count;

    logic [31:0] shadow [MEM_WORDS];
    logic [32:0] exp_q [$];                     // {fault, result} in issue order
    int          w_idx [N_WORDS];
    int          issued, received, errors, test_base, cycles, exp_faults;
    logic [31:0] exp_first;

    mem_subsys dut0 (
        .clk(clk), .rst(rst), .exu_valid(exu_valid), .lsu_ready(lsu_ready),
        .is_load(is_load), .is_store(is_store), .size(size), .load_unsigned(load_unsigned),
        .addr(addr), .wdata(wdata), .wbu_ready(wbu_ready), .lsu_valid(lsu_valid),
        .result(result), .access_fault(access_fault), .fault_clear(fault_clear),
        .fault_valid(fault_valid), .fault_addr(fault_addr), .fault_count(fault_count)
    );

    function automatic logic [32:0] expected_result(input logic ld, input logic st,
            input logic [2:0] sz, input logic uns, input logic [31:0] a);
        logic        flt;
        logic [31:0] lane;
        flt = (sz == SZ_HALF && a[0]) || (sz == SZ_WORD && a[1:0] != 2'b00) ||
              (a - MEM_BASE) >= 32'(MEM_WORDS * 4);
        if (!ld && !st) return {1'b0, a};
        if (st || flt) return {flt, st ? a : 32'h0};  // failed load reads as zero
        lane = shadow[a[MEM_AW+1:2]] >> (8 * a[1:0]);
        case (sz)
            SZ_BYTE: return {1'b0, uns ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]}};
            SZ_HALF: return {1'b0, uns ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]}};
            default: return {1'b0, lane};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic issue_op(input logic ld, input logic st, input logic [2:0] sz,
                            input logic uns, input logic [31:0] a, input logic [31:0] d);
        logic [32:0] exp;
        exp = expected_result(ld, st, sz, uns, a);
        exp_q.push_back(exp);
        issued++;
        if (exp[32]) begin
            if (exp_faults == 0) exp_first = a;
            if (exp_faults < 255) exp_faults++;
        end
        if (st && !exp[32]) begin
            case (sz)
                SZ_BYTE: shadow[a[MEM_AW+1:2]][8*a[1:0] +: 8] = d[7:0];
                SZ_HALF: shadow[a[MEM_AW+1:2]][8*a[1:0] +: 16] = d[15:0];
                default: shadow[a[MEM_AW+1:2]] = d;
            endcase
        end
        {exu_valid, is_load, is_store, size, load_unsigned} = {1'b1, ld, st, sz, uns};
        addr = a;
        wdata = d;
        while (!lsu_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);                         // accepted on this edge
        #1;
        exu_valid = 1'b0;
        check_value("lsu_ready", lsu_ready, 0); // one request in flight
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic finish_test(input string name);
        wait_drain();
        $display("%-24s %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    task automatic pulse_clear();
        fault_clear = 1'b1;
        @(posedge clk);
        #1;
        fault_clear = 1'b0;
    endtask

    task automatic drive_backpressure();
        forever begin
            @(posedge clk);
            #1;
            wbu_ready = ($urandom % 3) != 0;    // low about a third of cycles
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles with %0d results still owed", cycles, exp_q.size());
            $display("Test failed");
            $finish;
        end
    end

    always @(negedge clk) begin : compare
        logic [32:0] exp;
        if (!rst && lsu_valid && wbu_ready) begin
            received++;                         // every handover, expected or not
            if (exp_q.size() == 0) begin
                errors++;
                $display("a result was handed over with no request outstanding at %0t", $time);
            end else begin
                exp = exp_q.pop_front();
                check_value("result", result, exp[31:0]);
                check_value("access_fault", access_fault, exp[32]);
            end
        end
    end

    initial begin
        logic [31:0] a;
        {rst, fault_clear, exu_valid, is_load, is_store, load_unsigned} = 6'b100000;
        {size, addr, wdata, wbu_ready} = {SZ_WORD, 32'h0, 32'h0, 1'b1};
        void'($urandom(4));
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        fork
            drive_backpressure();
        join_none
        for (int i = 0; i < N_WORDS; i++) begin
            w_idx[i] = $urandom % MEM_WORDS;
            issue_op(0, 1, SZ_WORD, 0, MEM_BASE + 4 * w_idx[i], $urandom);
        end
        for (int i = 0; i < N_WORDS; i++) issue_op(1, 0, SZ_WORD, 0, MEM_BASE + 4 * w_idx[i], 0);
        finish_test("word store and load");
        for (int w = 0; w < 4; w++) begin
            a = MEM_BASE + 4 * ($urandom % MEM_WORDS);
            issue_op(0, 1, SZ_WORD, 0, a, $urandom);
            for (int off = 0; off < 4; off++) begin
                issue_op(1, 0, SZ_BYTE, 0, a + off, 0);
                issue_op(1, 0, SZ_BYTE, 1, a + off, 0);
            end
            for (int off = 0; off < 4; off += 2) begin
                issue_op(1, 0, SZ_HALF, 0, a + off, 0);
                issue_op(1, 0, SZ_HALF, 1, a + off, 0);
            end
        end
        finish_test("sub-word loads");
        for (int i = 0; i < N_SUB; i++) begin
            a = MEM_BASE + 4 * w_idx[i];
            if (i % 2 == 0) issue_op(0, 1, SZ_BYTE, 0, a + ($urandom % 4), $urandom);
            else issue_op(0, 1, SZ_HALF, 0, a + 2 * ($urandom % 2), $urandom);
            issue_op(1, 0, SZ_WORD, 0, a, 0);
        end
        finish_test("sub-word stores");
        pulse_clear();
        exp_faults = 0;
        issue_op(1, 0, SZ_WORD, 0, 32'h0000_0100, 0);              // below the window
        issue_op(1, 0, SZ_WORD, 0, MEM_BASE + 4 * w_idx[0], 0);
        issue_op(0, 1, SZ_WORD, 0, MEM_BASE + 32'h400, $urandom);  // one past the end
        issue_op(1, 0, SZ_HALF, 0, MEM_BASE + 5, 0);
        issue_op(0, 1, SZ_WORD, 0, MEM_BASE + 6, $urandom);
        issue_op(1, 0, SZ_WORD, 1, MEM_BASE + 32'h402, 0);
        wait_drain();
        check_value("fault_valid", fault_valid, 1);
        check_value("fault_addr", fault_addr, exp_first);
        check_value("fault_count", fault_count, exp_faults);
        pulse_clear();
        exp_faults = 0;
        check_value("fault_valid", fault_valid, 0);
        check_value("fault_addr", fault_addr, 0);
        check_value("fault_count", fault_count, 0);
        finish_test("faults and fault log");
        for (int i = 0; i < N_ALU; i++) begin
            issue_op(0, 0, 3'b001 << ($urandom % 3), $urandom % 2, $urandom, $urandom);
        end
        finish_test("non-memory passthrough");
        if (received != issued) begin
            errors++;
            $display("got %0d results for %0d requests", received, issued);
        end
        $display("%-24s %0d errors", "back-pressure ordering", errors - test_base);
        $display("issued %0d  received %0d  errors %0d", issued, received, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: mem_subsys.f
hdl/lsu_pkg.sv
hdl/lsu_core.sv
hdl/load_format.sv
hdl/axi_sram.sv
hdl/fault_log.sv
hdl/mem_subsys.sv
testbench/mem_subsys_assertions.sv
testbench/mem_subsys_tb.sv
